// ==== rtl/dnc_read_defines.svh ====
// Sizes are compile-time limits only; run-time sizes come from the config block
`ifndef DNC_READ_DEFINES_SVH
`define DNC_READ_DEFINES_SVH

//////////////////////////////
// Word widths
//////////////////////////////

// Data, weight and result words
`define DNC_DATA_WIDTH 16
// Size registers and counters
`define DNC_INDEX_WIDTH 8

//////////////////////////////
// Buffer limits
//////////////////////////////

// Depth of the h buffer and so the largest legal L
`define DNC_MAX_L 16
// Address bits into the h buffer
`define DNC_H_ADDR_WIDTH 4

`endif

// ==== rtl/dnc_read_pkg.sv ====
// Types only; widths follow dnc_read_defines.svh and must match its macros
`include "dnc_read_defines.svh"

package dnc_read_pkg;

  // h element, weight or result
  typedef logic [`DNC_DATA_WIDTH-1:0] data_t;
  // Size or counter value
  typedef logic [`DNC_INDEX_WIDTH-1:0] index_t;
  // Result tag
  typedef logic [1:0] field_t;
  // Config register address
  typedef logic [1:0] cfg_addr_t;

  // Field tags on the result stream
  localparam field_t field_key      = 2'd0;
  localparam field_t field_strength = 2'd1;
  localparam field_t field_free     = 2'd2;
  localparam field_t field_mode     = 2'd3;

  // Config addresses where 3 stores nothing
  localparam cfg_addr_t cfg_addr_r = 2'd0;
  localparam cfg_addr_t cfg_addr_l = 2'd1;
  localparam cfg_addr_t cfg_addr_w = 2'd2;

  // Sequencer states
  typedef enum logic [2:0] {
    st_idle, st_load_h, st_key, st_strength, st_free, st_mode, st_finish
  } seq_state_t;

endpackage

// ==== rtl/dnc_read_config.sv ====
// Writes are refused while busy; L is clamped to 1..DNC_MAX_L, zero R or W become 1
`timescale 1ns/1ps
`include "dnc_read_defines.svh"

module dnc_read_config import dnc_read_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  // Config write port
  input  logic      cfg_valid,
  output logic      cfg_ready,
  input  cfg_addr_t cfg_addr,
  input  index_t    cfg_data,
  // Run status from the sequencer
  input  logic      busy,
  // Sizes
  output index_t    size_r,
  output index_t    size_l,
  output index_t    size_w
);

  //////////////////////////////
  // Write handshake
  //////////////////////////////

  logic cfg_write;

  // Sizes frozen for the whole run
  assign cfg_ready = ~busy;
  assign cfg_write = cfg_valid & cfg_ready;

  //////////////////////////////
  // Size registers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_r <= index_t'(1);
      size_l <= index_t'(1);
      size_w <= index_t'(1);
    end else if (cfg_write) begin
      case (cfg_addr)
        cfg_addr_r: begin
          // Zero heads would never finish a run
          size_r <= (cfg_data == '0) ? index_t'(1) : cfg_data;
        end
        cfg_addr_l: begin
          // Limited by h buffer depth
          if (cfg_data == '0)
            size_l <= index_t'(1);
          else if (cfg_data > index_t'(`DNC_MAX_L))
            size_l <= index_t'(`DNC_MAX_L);
          else
            size_l <= cfg_data;
        end
        cfg_addr_w: begin
          size_w <= (cfg_data == '0) ? index_t'(1) : cfg_data;
        end
        default: begin
          // Address 3 accepted, nothing stored
        end
      endcase
    end
  end

endmodule

// ==== rtl/dnc_matvec_engine.sv ====
// One result in flight; size_l must stay stable from eng_start until the last row
`timescale 1ns/1ps
`include "dnc_read_defines.svh"

module dnc_matvec_engine import dnc_read_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  // Run control
  input  logic   eng_start,
  input  index_t size_l,
  // h stream
  input  logic   h_valid,
  output logic   h_ready,
  input  data_t  h_data,
  // Weight stream
  input  logic   w_valid,
  output logic   w_ready,
  input  data_t  w_data,
  // Row results
  output logic   row_valid,
  input  logic   row_ready,
  output data_t  row_data
);

  //////////////////////////////
  // State
  //////////////////////////////

  // h buffer indexed by column
  data_t  h_buf [`DNC_MAX_L];

  // Loading h, then streaming rows
  logic   loading;
  logic   active;
  // Element index shared by load and row phases
  index_t col;
  index_t last_col;
  data_t  acc;
  data_t  h_elem;
  data_t  product;

  logic   h_fire;
  logic   w_fire;
  logic   row_fire;
  logic   row_end;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign h_ready  = loading;
  // Stall weights while a result waits, unless it leaves this cycle
  assign w_ready  = active & ~loading & (~row_valid | row_ready);
  assign h_fire   = h_valid & h_ready;
  assign w_fire   = w_valid & w_ready;
  assign row_fire = row_valid & row_ready;

  assign last_col = index_t'(size_l - 1'b1);
  assign row_end  = (col == last_col);

  // Wrapping 16-bit multiply
  assign h_elem   = h_buf[col[`DNC_H_ADDR_WIDTH-1:0]];
  assign product  = w_data * h_elem;

  //////////////////////////////
  // h buffer write
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (h_fire)
      h_buf[col[`DNC_H_ADDR_WIDTH-1:0]] <= h_data;
  end

  //////////////////////////////
  // Control and accumulator
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      loading   <= 1'b0;
      active    <= 1'b0;
      col       <= '0;
      acc       <= '0;
      row_valid <= 1'b0;
    end else if (eng_start) begin
      // New run drops anything left over
      loading   <= 1'b1;
      active    <= 1'b1;
      col       <= '0;
      acc       <= '0;
      row_valid <= 1'b0;
    end else begin
      if (h_fire) begin
        if (row_end) begin
          loading <= 1'b0;
          col     <= '0;
        end else begin
          col <= col + 1'b1;
        end
      end
      if (w_fire) begin
        if (row_end) begin
          // Row done so the sum goes out next cycle
          col <= '0;
          acc <= '0;
        end else begin
          col <= col + 1'b1;
          acc <= acc + product;
        end
      end
      // A finished row replaces a result taken in the same cycle
      if (w_fire && row_end)
        row_valid <= 1'b1;
      else if (row_fire)
        row_valid <= 1'b0;
    end
  end

  // Result word
  always_ff @(posedge CLK) begin
    if (w_fire && row_end)
      row_data <= acc + product;
  end

endmodule

// ==== rtl/dnc_read_interface_vector.sv ====
// Assumes the weight stream follows key, strength, free, mode order; sizes stable while busy
`timescale 1ns/1ps
`include "dnc_read_defines.svh"

module dnc_read_interface_vector import dnc_read_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  // Run control
  input  logic   start,
  output logic   busy,
  output logic   done,
  // Sizes
  input  index_t size_r,
  input  index_t size_l,
  input  index_t size_w,
  // Engine control and h load observation
  output logic   eng_start,
  input  logic   h_valid,
  input  logic   h_ready,
  // Engine results
  input  logic   row_valid,
  output logic   row_ready,
  input  data_t  row_data,
  // Result stream
  output logic   res_valid,
  input  logic   res_ready,
  output data_t  res_data,
  output field_t res_field
);

  //////////////////////////////
  // Declarations
  //////////////////////////////

  seq_state_t state;
  index_t     h_count;
  // Wide enough for R*W
  logic [2*`DNC_INDEX_WIDTH-1:0] res_count;
  logic [2*`DNC_INDEX_WIDTH-1:0] field_limit;
  logic       in_field;
  logic       h_fire;
  logic       res_fire;
  logic       field_end;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign busy      = (state != st_idle) && (state != st_finish);
  assign done      = (state == st_finish);
  assign eng_start = start && (state == st_idle);
  assign in_field  = (state == st_key) || (state == st_strength) ||
                     (state == st_free) || (state == st_mode);

  // Result path straight through and tagged by state
  assign res_valid = row_valid & in_field;
  assign row_ready = res_ready & in_field;
  assign res_data  = row_data;

  always_comb begin
    case (state)
      st_strength: res_field = field_strength;
      st_free:     res_field = field_free;
      st_mode:     res_field = field_mode;
      default:     res_field = field_key;
    endcase
  end

  // Results per field
  always_comb begin
    case (state)
      st_key:  field_limit = {{`DNC_INDEX_WIDTH{1'b0}}, size_r} * {{`DNC_INDEX_WIDTH{1'b0}}, size_w};
      st_mode: field_limit = {{`DNC_INDEX_WIDTH{1'b0}}, size_r} * 3'd3;
      default: field_limit = {{`DNC_INDEX_WIDTH{1'b0}}, size_r};
    endcase
  end

  assign h_fire    = h_valid & h_ready;
  assign res_fire  = res_valid & res_ready;
  assign field_end = (res_count == field_limit - 1'b1);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      h_count   <= '0;
      res_count <= '0;
    end else begin
      case (state)
        st_idle: begin
          h_count   <= '0;
          res_count <= '0;
          if (start)
            state <= st_load_h;
        end
        st_load_h: begin
          // Leave once L h beats went into the engine
          if (h_fire) begin
            h_count <= h_count + 1'b1;
            if (h_count == index_t'(size_l - 1'b1))
              state <= st_key;
          end
        end
        st_key, st_strength, st_free, st_mode: begin
          if (res_fire) begin
            if (field_end) begin
              res_count <= '0;
              case (state)
                st_key:      state <= st_strength;
                st_strength: state <= st_free;
                st_free:     state <= st_mode;
                default:     state <= st_finish;
              endcase
            end else begin
              res_count <= res_count + 1'b1;
            end
          end
        end
        // One cycle of done
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== rtl/dnc_read_top.sv ====
// Sizes write only while idle; weight stream order must match the field order
`timescale 1ns/1ps

module dnc_read_top import dnc_read_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  // Config
  input  logic      cfg_valid,
  output logic      cfg_ready,
  input  cfg_addr_t cfg_addr,
  input  index_t    cfg_data,
  // Control
  input  logic      start,
  output logic      busy,
  output logic      done,
  // h stream
  input  logic      h_valid,
  output logic      h_ready,
  input  data_t     h_data,
  // Weight stream
  input  logic      w_valid,
  output logic      w_ready,
  input  data_t     w_data,
  // Result stream
  output logic      res_valid,
  input  logic      res_ready,
  output data_t     res_data,
  output field_t    res_field
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  index_t size_r;
  index_t size_l;
  index_t size_w;
  logic   eng_start;
  logic   row_valid;
  logic   row_ready;
  data_t  row_data;

  dnc_read_config u_config (
    .CLK(CLK), .RST(RST),
    .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
    .cfg_addr(cfg_addr), .cfg_data(cfg_data),
    .busy(busy),
    .size_r(size_r), .size_l(size_l), .size_w(size_w)
  );

  // Sequencer watches the h handshake to leave the load phase
  dnc_read_interface_vector u_seq (
    .CLK(CLK), .RST(RST),
    .start(start), .busy(busy), .done(done),
    .size_r(size_r), .size_l(size_l), .size_w(size_w),
    .eng_start(eng_start), .h_valid(h_valid), .h_ready(h_ready),
    .row_valid(row_valid), .row_ready(row_ready), .row_data(row_data),
    .res_valid(res_valid), .res_ready(res_ready),
    .res_data(res_data), .res_field(res_field)
  );

  dnc_matvec_engine u_engine (
    .CLK(CLK), .RST(RST),
    .eng_start(eng_start), .size_l(size_l),
    .h_valid(h_valid), .h_ready(h_ready), .h_data(h_data),
    .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data),
    .row_valid(row_valid), .row_ready(row_ready), .row_data(row_data)
  );

endmodule

// ==== bench/dnc_read_sva.sv ====
// Checks are off during reset; bound into every dnc_read_top instance
`timescale 1ns/1ps

module dnc_read_sva import dnc_read_pkg::*; (
  input logic   CLK,
  input logic   RST,
  input logic   busy,
  input logic   done,
  input logic   cfg_ready,
  input logic   w_ready,
  input logic   res_valid,
  input logic   res_ready,
  input data_t  res_data,
  input field_t res_field
);

  //////////////////////////////
  // Result stream
  //////////////////////////////

  // Stalled result stays put
  res_hold: assert property (@(posedge CLK) disable iff (RST)
    res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_field))
    else $error("Result changed while stalled");

  // No weights behind a stalled result
  w_stall: assert property (@(posedge CLK) disable iff (RST)
    res_valid && !res_ready |-> !w_ready)
    else $error("w_ready high behind a stalled result");

  //////////////////////////////
  // Control
  //////////////////////////////

  done_pulse: assert property (@(posedge CLK) disable iff (RST)
    done |=> !done)
    else $error("done longer than one cycle");

  // Sizes locked during a run
  cfg_lock: assert property (@(posedge CLK) disable iff (RST)
    busy |-> !cfg_ready)
    else $error("cfg_ready high while busy");

endmodule

bind dnc_read_top dnc_read_sva u_sva (
  .CLK(CLK), .RST(RST), .busy(busy), .done(done), .cfg_ready(cfg_ready),
  .w_ready(w_ready), .res_valid(res_valid), .res_ready(res_ready),
  .res_data(res_data), .res_field(res_field)
);

// ==== bench/dnc_read_tb.sv ====
// Must run from the project root, since it reads bench/dnc_read_tests.dat by relative path
`timescale 1ns/1ps
`include "dnc_read_defines.svh"

module dnc_read_tb import dnc_read_pkg::*; ();

  localparam int CLK_PERIOD = 100;

  logic      CLK;
  logic      RST;
  logic      cfg_valid;
  logic      cfg_ready;
  cfg_addr_t cfg_addr;
  index_t    cfg_data;
  logic      start;
  logic      busy;
  logic      done;
  logic      h_valid;
  logic      h_ready;
  data_t     h_data;
  logic      w_valid;
  logic      w_ready;
  data_t     w_data;
  logic      res_valid;
  logic      res_ready;
  data_t     res_data;
  field_t    res_field;

  // Flat word image of the test file
  data_t tests_mem [0:1023];
  int    rec_base [0:15];
  int    errors;
  int    done_count;

  dnc_read_top UUT (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // done pulses seen so far
  always @(posedge CLK) begin
    if (done)
      done_count <= done_count + 1;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s is 0x%04h, expected 0x%04h at %0t ns",
               name, actual, expected, $time);
    end
  endtask

  // Size as the config block stores a written value
  function automatic int stored_size(input index_t raw, input int limit);
    if (raw == '0)
      return 1;
    else if (int'(raw) > limit)
      return limit;
    else
      return int'(raw);
  endfunction

  function automatic int h_length(input int p);
    return stored_size(tests_mem[p+1][7:0], `DNC_MAX_L);
  endfunction

  // Rows per run as R*(W+5)
  function automatic int field_rows(input int p);
    return stored_size(tests_mem[p][7:0], 255) * (stored_size(tests_mem[p+2][7:0], 255) + 5);
  endfunction

  task automatic write_config(input cfg_addr_t addr, input index_t data);
    cfg_valid <= 1'b1;
    cfg_addr  <= addr;
    cfg_data  <= data;
    @(posedge CLK);
    while (!cfg_ready)
      @(posedge CLK);
    cfg_valid <= 1'b0;
  endtask

  task automatic send_h(input int base, input int count, input bit gaps);
    for (int i = 0; i < count; i++) begin
      while (gaps && ($urandom % 4 == 0)) begin
        h_valid <= 1'b0;
        @(posedge CLK);
      end
      h_valid <= 1'b1;
      h_data  <= tests_mem[base + i];
      @(posedge CLK);
      while (!h_ready)
        @(posedge CLK);
    end
    h_valid <= 1'b0;
  endtask

  task automatic send_w(input int base, input int count, input bit gaps);
    for (int i = 0; i < count; i++) begin
      while (gaps && ($urandom % 4 == 0)) begin
        w_valid <= 1'b0;
        @(posedge CLK);
      end
      w_valid <= 1'b1;
      w_data  <= tests_mem[base + i];
      @(posedge CLK);
      while (!w_ready)
        @(posedge CLK);
    end
    w_valid <= 1'b0;
  endtask

  // Field and value pairs in stream order
  task automatic collect_results(input int base, input int count, input bit gaps);
    int n;
    n = 0;
    while (n < count) begin
      res_ready <= gaps ? (($urandom % 3) != 0) : 1'b1;
      @(posedge CLK);
      if (res_valid && res_ready) begin
        check_value("res_field", data_t'(res_field), tests_mem[base + 2 * n]);
        check_value("res_data", res_data, tests_mem[base + 2 * n + 1]);
        n++;
      end
    end
    res_ready <= 1'b0;
  endtask

  // Stray start and R write in mid-run must both be ignored
  task automatic poke_while_busy();
    @(posedge CLK);
    while (!busy)
      @(posedge CLK);
    start     <= 1'b1;
    cfg_valid <= 1'b1;
    cfg_addr  <= cfg_addr_r;
    cfg_data  <= 8'h07;
    @(posedge CLK);
    check_value("cfg_ready", data_t'(cfg_ready), 16'h0000);
    start     <= 1'b0;
    cfg_valid <= 1'b0;
  endtask

  task automatic run_record(input int p, input int run);
    int l_len;
    int rows;
    bit gaps;
    l_len = h_length(p);
    rows  = field_rows(p);
    gaps  = (tests_mem[p+3] != '0);
    write_config(cfg_addr_r, tests_mem[p][7:0]);
    write_config(cfg_addr_l, tests_mem[p+1][7:0]);
    write_config(cfg_addr_w, tests_mem[p+2][7:0]);
    // Address 3 must leave every size as written
    write_config(cfg_addr_t'(3), 8'h04);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    fork
      send_h(p + 4, l_len, gaps);
      send_w(p + 4 + l_len, rows * l_len, gaps);
      collect_results(p + 4 + l_len + rows * l_len, rows, gaps);
      poke_while_busy();
    join
    // done one cycle after the last result
    @(posedge CLK);
    check_value("done", data_t'(done), 16'h0001);
    check_value("busy", data_t'(busy), 16'h0000);
    @(posedge CLK);
    check_value("done", data_t'(done), 16'h0000);
    check_value("res_valid", data_t'(res_valid), 16'h0000);
    check_value("done_count", data_t'(done_count), data_t'(run + 1));
  endtask

  //////////////////////////////
  // Main flow
  //////////////////////////////

  initial begin : main_flow
    int p;
    int n_rec;
    int rows;
    int l_len;
    int total_beats;
    CLK        = 1'b0;
    RST        = 1'b1;
    cfg_valid  = 1'b0;
    cfg_addr   = '0;
    cfg_data   = '0;
    start      = 1'b0;
    h_valid    = 1'b0;
    h_data     = '0;
    w_valid    = 1'b0;
    w_data     = '0;
    res_ready  = 1'b0;
    errors     = 0;
    done_count = 0;
    void'($urandom(32'h57cbbc42));
    $readmemh("bench/dnc_read_tests.dat", tests_mem);
    n_rec = 0;
    if ($isunknown(tests_mem[0])) begin
      errors++;
      $display("Test file bench/dnc_read_tests.dat is missing or empty");
    end else begin
      n_rec = (int'(tests_mem[0]) > 16) ? 16 : int'(tests_mem[0]);
    end
    // Reset cycles count as beats too
    total_beats = 8;
    p = 1;
    for (int rec = 0; rec < n_rec; rec++) begin
      rec_base[rec] = p;
      l_len = h_length(p);
      rows  = field_rows(p);
      total_beats += 4 + l_len + rows * l_len + rows;
      p += 4 + l_len + rows * l_len + 2 * rows;
    end
    fork
      begin : watchdog
        #(20 * total_beats * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run timed out", 20 * total_beats);
        $display("Summary: %0d errors before the timeout", errors);
        $display("** FAIL **");
        $finish;
      end
    join_none
    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    check_value("busy", data_t'(busy), 16'h0000);
    check_value("done", data_t'(done), 16'h0000);
    check_value("res_valid", data_t'(res_valid), 16'h0000);
    check_value("h_ready", data_t'(h_ready), 16'h0000);
    check_value("w_ready", data_t'(w_ready), 16'h0000);
    check_value("cfg_ready", data_t'(cfg_ready), 16'h0001);
    for (int rec = 0; rec < n_rec; rec++)
      run_record(rec_base[rec], rec);
    $display("Summary: %0d errors in %0d runs", errors, n_rec);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== bench/dnc_read_tests.dat ====
// Word 0 is the record count; each record is R L W gaps, then L h words,
// then R*(W+5)*L weights row by row, then R*(W+5) pairs of field and expected result
0004
// Run 1, R=1 L=2 W=2, no gaps
0001 0002 0002 0000
0003 0005
0001 0002 0004 0000 0000 0001 0002 0002
0007 0003 0000 0000 0001 0001
0000 000d 0000 000c 0001 0005 0002 0010 0003 0024 0003 0000 0003 0008
// Run 2, R=2 L=5 W=3, no gaps
0002 0005 0003 0000
0001 0002 0003 0004 0005
0001 0000 0000 0000 0000 0000 0001 0000 0000 0000
0000 0000 0001 0000 0000 0000 0000 0000 0001 0000
0000 0000 0000 0000 0001 0001 0001 0001 0001 0001
0002 0000 0000 0000 0001 0000 0003 0000 0000 0000
0001 0002 0003 0004 0005 0005 0004 0003 0002 0001
0000 0000 0000 0000 0002 0000 0000 0002 0000 0000
0003 0000 0000 0001 0000 0000 0000 0000 0000 0000
0001 0000 0001 0000 0001 0000 0001 0000 0001 0000
0000 0001 0000 0002 0000 0003 0000 0004 0000 0005 0000 000f
0001 0007 0001 0006 0002 0037 0002 0023
0003 000a 0003 0006 0003 0007 0003 0000 0003 0009 0003 0006
// Run 3, R=1 L=3 W=1 with gaps, sums wrap
0001 0003 0001 0001
ffff 0002 0010
0001 0001 0000 0002 0000 0001 0000 8000 0000
0000 0003 0004 ffff 0000 0000 0001 0001 0001
0000 0001 0001 000e 0002 0000 0003 0046 0003 0001 0003 0011
// Run 4, L written as 0 runs with one h word, products wrap
0001 0000 0001 0000
0100
0100 0203 00ff ffff 1234 0001
0000 0000 0001 0300 0002 ff00 0003 ff00 0003 3400 0003 0100

// ==== list.f ====
+incdir+rtl
rtl/dnc_read_pkg.sv
rtl/dnc_read_config.sv
rtl/dnc_matvec_engine.sv
rtl/dnc_read_interface_vector.sv
rtl/dnc_read_top.sv
bench/dnc_read_sva.sv
bench/dnc_read_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module dnc_read_tb -o dnc_read_sim
	./obj_dir/dnc_read_sim > sim.log 2>&1; cat sim.log
	! grep -qF '** FAIL **' sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
